// ==== boot_rom.sv ====
//****************************************
// Boot ROM target
// Word memory loaded from a hex file
//****************************************
`timescale 1ns/1ns
`default_nettype none

module boot_rom
   import periph_pkg::*;
(
   input  wire          i_clk,
   input  wire          i_rst_n,
   periph_bus_if.target bus
);

   data_t             mem [ROM_WORDS];
   logic [ROM_AW-1:0] idx;

   initial begin
      $readmemh(ROM_FILE, mem);
   end

   // Offsets past the end wrap onto the array
   assign idx = bus.off[ROM_AW-1:0];

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         bus.ack <= 1'b0;
         bus.err <= 1'b0;
      end else begin
         bus.ack <= bus.req;
         // Writes are refused
         bus.err <= bus.req && bus.we;
      end
   end

   always_ff @(posedge i_clk) begin
      if (bus.req) begin
         bus.rdata <= mem[idx];
      end
   end

endmodule

`default_nettype wire

// ==== bootrom.hex ====
// One 32-bit ROM word per line, word offsets 0 to 15 in order
00000297
02028293
0002a303
00130313
0062a023
ff5ff06f
00001537
00050513
00052583
00b52223
00002637
00060613
00462683
fe068ee3
00000013
0000006f

// ==== flist.f ====
periph_pkg.sv
periph_bus_if.sv
periph_bus_ctrl.sv
boot_rom.sv
syscon_gpio.sv
syscon_timer.sv
periph_subsys_top.sv
tb_periph_subsys.sv

// ==== periph_bus_ctrl.sv ====
//****************************************
// AXI4-Lite slave controller
// Address decode, request issue to the
// targets and response hold
//****************************************
`timescale 1ns/1ns
`default_nettype none

module periph_bus_ctrl
   import periph_pkg::*;
(
   input  wire            i_clk,
   input  wire            i_rst_n,
   // AXI4-Lite slave
   input  wire axi_addr_t i_s_axil_awaddr,
   input  wire            i_s_axil_awvalid,
   output logic           o_s_axil_awready,
   input  wire data_t     i_s_axil_wdata,
   input  wire strb_t     i_s_axil_wstrb,
   input  wire            i_s_axil_wvalid,
   output logic           o_s_axil_wready,
   output resp_t          o_s_axil_bresp,
   output logic           o_s_axil_bvalid,
   input  wire            i_s_axil_bready,
   input  wire axi_addr_t i_s_axil_araddr,
   input  wire            i_s_axil_arvalid,
   output logic           o_s_axil_arready,
   output data_t          o_s_axil_rdata,
   output resp_t          o_s_axil_rresp,
   output logic           o_s_axil_rvalid,
   input  wire            i_s_axil_rready,
   // Targets
   periph_bus_if.ctrl     rom_bus,
   periph_bus_if.ctrl     gpio_bus,
   periph_bus_if.ctrl     timer_bus
);

   ctrl_state_t state;
   logic        wr_q;
   logic        sel_rom_q;
   logic        sel_gpio_q;
   logic        sel_timer_q;
   reg_off_t    off_q;
   data_t       wdata_q;
   strb_t       wstrb_q;
   data_t       rdata_q;
   resp_t       resp_q;

   logic        rd_go;
   logic        wr_go;
   axi_addr_t   addr;
   axi_addr_t   region;
   logic        upper_ok;
   logic        hit_rom;
   logic        hit_gpio;
   logic        hit_timer;

   logic        t_ack;
   logic        t_err;
   data_t       t_rdata;

   //****************************************
   // Address acceptance and decode
   //****************************************
   // Read wins when both are pending
   assign rd_go = (state == ST_IDLE) && i_s_axil_arvalid;
   assign wr_go = (state == ST_IDLE) && !i_s_axil_arvalid &&
                  i_s_axil_awvalid && i_s_axil_wvalid;

   // Write address and data only complete together
   assign o_s_axil_arready = (state == ST_IDLE);
   assign o_s_axil_awready = (state == ST_IDLE) && !i_s_axil_arvalid && i_s_axil_wvalid;
   assign o_s_axil_wready  = (state == ST_IDLE) && !i_s_axil_arvalid && i_s_axil_awvalid;

   assign addr      = i_s_axil_arvalid ? i_s_axil_araddr : i_s_axil_awaddr;
   assign region    = addr & REGION_MASK;
   assign upper_ok  = (addr[ADDR_W-1:MAP_W] == '0);
   assign hit_rom   = upper_ok && (region == ROM_BASE);
   assign hit_gpio  = upper_ok && (region == GPIO_BASE);
   assign hit_timer = upper_ok && (region == TIMER_BASE);

   // Response from the selected target
   always_comb begin
      t_ack   = 1'b0;
      t_err   = 1'b0;
      t_rdata = '0;
      if (sel_rom_q) begin
         t_ack   = rom_bus.ack;
         t_err   = rom_bus.err;
         t_rdata = rom_bus.rdata;
      end else if (sel_gpio_q) begin
         t_ack   = gpio_bus.ack;
         t_err   = gpio_bus.err;
         t_rdata = gpio_bus.rdata;
      end else if (sel_timer_q) begin
         t_ack   = timer_bus.ack;
         t_err   = timer_bus.err;
         t_rdata = timer_bus.rdata;
      end
   end

   //****************************************
   // Transaction FSM
   //****************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state       <= ST_IDLE;
         wr_q        <= 1'b0;
         sel_rom_q   <= 1'b0;
         sel_gpio_q  <= 1'b0;
         sel_timer_q <= 1'b0;
         resp_q      <= RESP_OKAY;
      end else begin
         case (state)
            ST_IDLE: begin
               if (rd_go || wr_go) begin
                  wr_q        <= wr_go;
                  sel_rom_q   <= hit_rom;
                  sel_gpio_q  <= hit_gpio;
                  sel_timer_q <= hit_timer;
                  if (hit_rom || hit_gpio || hit_timer) begin
                     state <= ST_REQ;
                  end else begin
                     // Unmapped address answered without a target
                     resp_q <= RESP_DECERR;
                     state  <= ST_RESP;
                  end
               end
            end
            ST_REQ: begin
               state <= ST_WAIT;
            end
            ST_WAIT: begin
               if (t_ack) begin
                  resp_q <= t_err ? RESP_SLVERR : RESP_OKAY;
                  state  <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (wr_q ? i_s_axil_bready : i_s_axil_rready) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Request payload and read data
   always_ff @(posedge i_clk) begin
      if (rd_go || wr_go) begin
         off_q   <= addr[OFF_W+1:2];
         wdata_q <= i_s_axil_wdata;
         wstrb_q <= i_s_axil_wstrb;
         rdata_q <= '0;
      end else if ((state == ST_WAIT) && t_ack) begin
         rdata_q <= t_rdata;
      end
   end

   // One-cycle request to the selected target
   assign rom_bus.req     = (state == ST_REQ) && sel_rom_q;
   assign rom_bus.we      = wr_q;
   assign rom_bus.off     = off_q;
   assign rom_bus.wdata   = wdata_q;
   assign rom_bus.wstrb   = wstrb_q;

   assign gpio_bus.req    = (state == ST_REQ) && sel_gpio_q;
   assign gpio_bus.we     = wr_q;
   assign gpio_bus.off    = off_q;
   assign gpio_bus.wdata  = wdata_q;
   assign gpio_bus.wstrb  = wstrb_q;

   assign timer_bus.req   = (state == ST_REQ) && sel_timer_q;
   assign timer_bus.we    = wr_q;
   assign timer_bus.off   = off_q;
   assign timer_bus.wdata = wdata_q;
   assign timer_bus.wstrb = wstrb_q;

   // Responses held in ST_RESP until accepted
   assign o_s_axil_rvalid = (state == ST_RESP) && !wr_q;
   assign o_s_axil_bvalid = (state == ST_RESP) && wr_q;
   assign o_s_axil_rdata  = rdata_q;
   assign o_s_axil_rresp  = resp_q;
   assign o_s_axil_bresp  = resp_q;

endmodule

`default_nettype wire

// ==== periph_bus_if.sv ====
//****************************************
// Request/acknowledge bus between the
// controller and the peripheral targets
//****************************************
`timescale 1ns/1ns
`default_nettype none

interface periph_bus_if
   import periph_pkg::*;
();

   // Controller side
   logic     req;
   logic     we;
   reg_off_t off;
   data_t    wdata;
   strb_t    wstrb;
   // Target side, valid in the ack cycle
   data_t    rdata;
   logic     ack;
   logic     err;

   modport ctrl (
      output req, we, off, wdata, wstrb,
      input  rdata, ack, err
   );

   modport target (
      input  req, we, off, wdata, wstrb,
      output rdata, ack, err
   );

endinterface

`default_nettype wire

// ==== periph_pkg.sv ====
//****************************************
// Peripheral subsystem shared definitions
// Bus widths, address map, register offsets,
// AXI response codes, types and FSM states
//****************************************
`default_nettype none

package periph_pkg;

   // Bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int IRQ_W  = 3;
   localparam int OFF_W  = 4;
   // Address bits covered by the map
   // Any set bit above them is unmapped
   localparam int MAP_W  = 16;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] axi_addr_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [1:0]        resp_t;
   typedef logic [IRQ_W-1:0]  irq_t;
   typedef logic [OFF_W-1:0]  reg_off_t;

   // Boot ROM
   localparam int ROM_WORDS = 16;
   localparam int ROM_AW    = $clog2(ROM_WORDS);
   localparam     ROM_FILE  = "bootrom.hex";

   //****************************************
   // Address map, 4 KB regions
   //****************************************
   localparam axi_addr_t ROM_BASE    = 32'h0000_0000;
   localparam axi_addr_t GPIO_BASE   = 32'h0000_1000;
   localparam axi_addr_t TIMER_BASE  = 32'h0000_2000;
   localparam axi_addr_t REGION_MASK = 32'h0000_F000;

   // Word offsets inside the regions
   localparam reg_off_t GPIO_OUT_OFF  = 4'd0;
   localparam reg_off_t GPIO_IN_OFF   = 4'd1;
   localparam reg_off_t TIMER_CNT_OFF = 4'd0;
   localparam reg_off_t TIMER_CMP_OFF = 4'd1;
   localparam reg_off_t TIMER_SW_OFF  = 4'd2;

   // AXI responses
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;
   localparam resp_t RESP_DECERR = 2'b11;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_WAIT,
      ST_RESP
   } ctrl_state_t;

   // Replace the strobed bytes of a register
   function automatic data_t merge_bytes(input data_t cur, input data_t wdata,
                                         input strb_t strb);
      data_t res;
      res = cur;
      for (int i = 0; i < STRB_W; i++) begin
         if (strb[i]) begin
            res[i*8 +: 8] = wdata[i*8 +: 8];
         end
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// ==== periph_subsys_top.sv ====
//****************************************
// Peripheral subsystem top level
// AXI4-Lite controller with boot ROM,
// GPIO and timer targets
//****************************************
`timescale 1ns/1ns
`default_nettype none

module periph_subsys_top
   import periph_pkg::*;
(
   input  wire            i_clk,
   input  wire            i_rst_n,
   // GPIO and interrupts
   input  wire data_t     i_gpio,
   output data_t          o_gpio,
   output irq_t           o_irq,
   // AXI4-Lite slave
   input  wire axi_addr_t i_s_axil_awaddr,
   input  wire            i_s_axil_awvalid,
   output logic           o_s_axil_awready,
   input  wire data_t     i_s_axil_wdata,
   input  wire strb_t     i_s_axil_wstrb,
   input  wire            i_s_axil_wvalid,
   output logic           o_s_axil_wready,
   output resp_t          o_s_axil_bresp,
   output logic           o_s_axil_bvalid,
   input  wire            i_s_axil_bready,
   input  wire axi_addr_t i_s_axil_araddr,
   input  wire            i_s_axil_arvalid,
   output logic           o_s_axil_arready,
   output data_t          o_s_axil_rdata,
   output resp_t          o_s_axil_rresp,
   output logic           o_s_axil_rvalid,
   input  wire            i_s_axil_rready
);

   periph_bus_if rom_bus ();
   periph_bus_if gpio_bus ();
   periph_bus_if timer_bus ();

   periph_bus_ctrl u_ctrl (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_s_axil_awaddr  (i_s_axil_awaddr),
      .i_s_axil_awvalid (i_s_axil_awvalid),
      .o_s_axil_awready (o_s_axil_awready),
      .i_s_axil_wdata   (i_s_axil_wdata),
      .i_s_axil_wstrb   (i_s_axil_wstrb),
      .i_s_axil_wvalid  (i_s_axil_wvalid),
      .o_s_axil_wready  (o_s_axil_wready),
      .o_s_axil_bresp   (o_s_axil_bresp),
      .o_s_axil_bvalid  (o_s_axil_bvalid),
      .i_s_axil_bready  (i_s_axil_bready),
      .i_s_axil_araddr  (i_s_axil_araddr),
      .i_s_axil_arvalid (i_s_axil_arvalid),
      .o_s_axil_arready (o_s_axil_arready),
      .o_s_axil_rdata   (o_s_axil_rdata),
      .o_s_axil_rresp   (o_s_axil_rresp),
      .o_s_axil_rvalid  (o_s_axil_rvalid),
      .i_s_axil_rready  (i_s_axil_rready),
      .rom_bus          (rom_bus.ctrl),
      .gpio_bus         (gpio_bus.ctrl),
      .timer_bus        (timer_bus.ctrl)
   );

   // Targets
   boot_rom u_boot_rom (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .bus     (rom_bus.target)
   );

   syscon_gpio u_gpio (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .bus     (gpio_bus.target),
      .i_gpio  (i_gpio),
      .o_gpio  (o_gpio)
   );

   syscon_timer u_timer (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .bus     (timer_bus.target),
      .o_irq   (o_irq)
   );

endmodule

`default_nettype wire

// ==== syscon_gpio.sv ====
//****************************************
// GPIO target
// Output register with byte strobes
// and sampled input
//****************************************
`timescale 1ns/1ns
`default_nettype none

module syscon_gpio
   import periph_pkg::*;
(
   input  wire          i_clk,
   input  wire          i_rst_n,
   periph_bus_if.target bus,
   input  wire data_t   i_gpio,
   output data_t        o_gpio
);

   data_t gpio_out_q;
   data_t gpio_in_q;

   // Input sample register
   always_ff @(posedge i_clk) begin
      gpio_in_q <= i_gpio;
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         gpio_out_q <= '0;
         bus.ack    <= 1'b0;
      end else begin
         bus.ack <= bus.req;
         if (bus.req && bus.we && (bus.off == GPIO_OUT_OFF)) begin
            gpio_out_q <= merge_bytes(gpio_out_q, bus.wdata, bus.wstrb);
         end
      end
   end

   // Unused offsets read zero
   always_ff @(posedge i_clk) begin
      if (bus.req) begin
         case (bus.off)
            GPIO_OUT_OFF: bus.rdata <= gpio_out_q;
            GPIO_IN_OFF:  bus.rdata <= gpio_in_q;
            default:      bus.rdata <= '0;
         endcase
      end
   end

   // No access here is an error
   assign bus.err = 1'b0;

   assign o_gpio = gpio_out_q;

endmodule

`default_nettype wire

// ==== syscon_timer.sv ====
//****************************************
// Timer and interrupt target
// Free-running count, compare register,
// software interrupt bits, irq vector
//****************************************
`timescale 1ns/1ns
`default_nettype none

module syscon_timer
   import periph_pkg::*;
(
   input  wire          i_clk,
   input  wire          i_rst_n,
   periph_bus_if.target bus,
   output irq_t         o_irq
);

   data_t            count_q;
   data_t            cmp_q;
   logic [IRQ_W-2:0] sw_irq_q;
   logic             timer_irq;

   //****************************************
   // Registers
   //****************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         count_q  <= '0;
         cmp_q    <= '1;
         sw_irq_q <= '0;
         bus.ack  <= 1'b0;
      end else begin
         count_q <= count_q + 1'b1;
         bus.ack <= bus.req;
         if (bus.req && bus.we) begin
            case (bus.off)
               TIMER_CMP_OFF: begin
                  cmp_q <= merge_bytes(cmp_q, bus.wdata, bus.wstrb);
               end
               TIMER_SW_OFF: begin
                  if (bus.wstrb[0]) begin
                     sw_irq_q <= bus.wdata[IRQ_W-2:0];
                  end
               end
               // Count is read-only
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (bus.req) begin
         case (bus.off)
            TIMER_CNT_OFF: bus.rdata <= count_q;
            TIMER_CMP_OFF: bus.rdata <= cmp_q;
            TIMER_SW_OFF:  bus.rdata <= data_t'(sw_irq_q);
            default:       bus.rdata <= '0;
         endcase
      end
   end

   assign bus.err = 1'b0;

   //****************************************
   // Interrupts
   //****************************************
   assign timer_irq = (count_q >= cmp_q);

   // Bit 0 timer, bit 1 soft irq 3, bit 2 soft irq 4
   assign o_irq = {sw_irq_q, timer_irq};

endmodule

`default_nettype wire

// ==== tb_periph_subsys.sv ====
//****************************************
// Directed testbench for the peripheral
// subsystem with AXI4-Lite tasks, compare
// tasks, six tests and a cycle timeout
//****************************************
`timescale 1ns/1ns
`default_nettype none

module tb_periph_subsys
   import periph_pkg::*;
();

   localparam int DRV_DLY        = 2;
   // Six tests of up to 40 transactions at 12 cycles plus reset margin
   localparam int TIMEOUT_CYCLES = 6 * 40 * 12 + 120;

   logic      i_clk;
   logic      i_rst_n;
   data_t     i_gpio;
   data_t     o_gpio;
   irq_t      o_irq;
   axi_addr_t i_s_axil_awaddr;
   logic      i_s_axil_awvalid;
   logic      o_s_axil_awready;
   data_t     i_s_axil_wdata;
   strb_t     i_s_axil_wstrb;
   logic      i_s_axil_wvalid;
   logic      o_s_axil_wready;
   resp_t     o_s_axil_bresp;
   logic      o_s_axil_bvalid;
   logic      i_s_axil_bready;
   axi_addr_t i_s_axil_araddr;
   logic      i_s_axil_arvalid;
   logic      o_s_axil_arready;
   data_t     o_s_axil_rdata;
   resp_t     o_s_axil_rresp;
   logic      o_s_axil_rvalid;
   logic      i_s_axil_rready;

   data_t     rom_exp [ROM_WORDS];
   int        err_count  = 0;
   int        pass_tests = 0;
   int        fail_tests = 0;
   int        cycle_cnt  = 0;
   int        seed_val;

   periph_subsys_top dut (.*);

   initial i_clk = 1'b0;
   always #20 i_clk = ~i_clk;

   // Watchdog
   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("ERROR: timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
         $display("test failed");
         $finish;
      end
   end

   //****************************************
   // Compare tasks
   //****************************************
   task automatic check_data(input string msg, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
         err_count++;
      end
   endtask

   task automatic check_resp(input string msg, input resp_t got, input resp_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
         err_count++;
      end
   endtask

   task automatic check_irq(input string msg, input irq_t got, input irq_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s, got %b expected %b", $time, msg, got, exp);
         err_count++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      err_count++;
   endtask

   //****************************************
   // AXI4-Lite transfers
   //****************************************
   task automatic axil_write(input axi_addr_t addr, input data_t data, input strb_t strb,
                             input int stall, output resp_t resp);
      resp_t held;
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_awaddr  = addr;
      i_s_axil_wdata   = data;
      i_s_axil_wstrb   = strb;
      i_s_axil_awvalid = 1'b1;
      i_s_axil_wvalid  = 1'b1;
      @(negedge i_clk);
      while (!(o_s_axil_awready && o_s_axil_wready)) @(negedge i_clk);
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_awvalid = 1'b0;
      i_s_axil_wvalid  = 1'b0;
      @(negedge i_clk);
      while (!o_s_axil_bvalid) @(negedge i_clk);
      held = o_s_axil_bresp;
      for (int i = 0; i < stall; i++) begin
         @(negedge i_clk);
         if (!o_s_axil_bvalid) note_failure("bvalid dropped while bready was low");
         if (o_s_axil_arready) note_failure("arready high while bvalid was pending");
         check_resp("bresp held under back-pressure", o_s_axil_bresp, held);
      end
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_bready = 1'b1;
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_bready = 1'b0;
      resp = held;
   endtask

   task automatic axil_read(input axi_addr_t addr, input int stall,
                            output data_t data, output resp_t resp);
      data_t held_data;
      resp_t held_resp;
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_araddr  = addr;
      i_s_axil_arvalid = 1'b1;
      @(negedge i_clk);
      while (!o_s_axil_arready) @(negedge i_clk);
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_arvalid = 1'b0;
      @(negedge i_clk);
      while (!o_s_axil_rvalid) @(negedge i_clk);
      held_data = o_s_axil_rdata;
      held_resp = o_s_axil_rresp;
      for (int i = 0; i < stall; i++) begin
         @(negedge i_clk);
         if (!o_s_axil_rvalid) note_failure("rvalid dropped while rready was low");
         if (o_s_axil_arready) note_failure("arready high while rvalid was pending");
         check_data("rdata held under back-pressure", o_s_axil_rdata, held_data);
         check_resp("rresp held under back-pressure", o_s_axil_rresp, held_resp);
      end
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_rready = 1'b1;
      @(posedge i_clk);
      #DRV_DLY;
      i_s_axil_rready = 1'b0;
      data = held_data;
      resp = held_resp;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         pass_tests++;
         $display("%s: ok", name);
      end else begin
         fail_tests++;
         $display("%s: %0d errors", name, err_count - errs_before);
      end
   endtask

   //****************************************
   // Tests
   //****************************************
   task automatic rom_reads();
      int    e0;
      data_t d;
      resp_t r;
      e0 = err_count;
      for (int i = 0; i < ROM_WORDS; i++) begin
         axil_read(ROM_BASE + axi_addr_t'(i * 4), 0, d, r);
         check_data($sformatf("ROM word %0d", i), d, rom_exp[i]);
         check_resp($sformatf("ROM word %0d response", i), r, RESP_OKAY);
      end
      finish_test("ROM reads", e0);
   endtask

   task automatic rom_write();
      int    e0;
      data_t d;
      resp_t r;
      e0 = err_count;
      axil_write(ROM_BASE + 32'h14, $urandom, 4'hf, 0, r);
      check_resp("ROM write response", r, RESP_SLVERR);
      axil_read(ROM_BASE + 32'h14, 0, d, r);
      check_data("ROM word 5 after write", d, rom_exp[5]);
      check_resp("ROM read after write", r, RESP_OKAY);
      finish_test("ROM write", e0);
   endtask

   task automatic gpio_access();
      int    e0;
      data_t w1;
      data_t w2;
      data_t exp;
      data_t d;
      resp_t r;
      e0 = err_count;
      w1 = $urandom;
      w2 = $urandom;
      axil_write(GPIO_BASE, w1, 4'hf, 0, r);
      check_resp("GPIO full write", r, RESP_OKAY);
      axil_write(GPIO_BASE, w2, 4'b0101, 0, r);
      check_resp("GPIO partial write", r, RESP_OKAY);
      // Bytes 0 and 2 from the second write
      exp = {w1[31:24], w2[23:16], w1[15:8], w2[7:0]};
      check_data("o_gpio after byte merge", o_gpio, exp);
      axil_read(GPIO_BASE, 0, d, r);
      check_data("GPIO output readback", d, exp);
      check_resp("GPIO output readback response", r, RESP_OKAY);
      @(posedge i_clk);
      #DRV_DLY;
      i_gpio = $urandom;
      repeat (2) @(posedge i_clk);
      axil_read(GPIO_BASE + 32'h4, 0, d, r);
      check_data("GPIO input sample", d, i_gpio);
      check_resp("GPIO input response", r, RESP_OKAY);
      finish_test("GPIO", e0);
   endtask

   task automatic timer_irq();
      int    e0;
      data_t c1;
      data_t c2;
      resp_t r;
      e0 = err_count;
      axil_read(TIMER_BASE, 0, c1, r);
      check_resp("Timer count read", r, RESP_OKAY);
      axil_read(TIMER_BASE, 0, c2, r);
      if (c2 <= c1) note_failure("timer count did not increase between reads");
      axil_write(TIMER_BASE + 32'h4, 32'h0, 4'hf, 0, r);
      check_resp("Compare write zero", r, RESP_OKAY);
      @(negedge i_clk);
      check_irq("irq with compare zero", o_irq, 3'b001);
      axil_write(TIMER_BASE + 32'h4, 32'hffff_ffff, 4'hf, 0, r);
      check_resp("Compare write all ones", r, RESP_OKAY);
      @(negedge i_clk);
      check_irq("irq with compare all ones", o_irq, 3'b000);
      finish_test("Timer interrupt", e0);
   endtask

   task automatic soft_irq_decerr();
      int    e0;
      data_t d;
      resp_t r;
      e0 = err_count;
      for (int v = 1; v < 4; v++) begin
         axil_write(TIMER_BASE + 32'h8, data_t'(v), 4'hf, 0, r);
         check_resp("Soft irq write", r, RESP_OKAY);
         @(negedge i_clk);
         check_irq("Soft irq bits", o_irq, {v[1:0], 1'b0});
      end
      axil_write(TIMER_BASE + 32'h8, 32'h0, 4'hf, 0, r);
      check_resp("Soft irq clear", r, RESP_OKAY);
      axil_read(32'h3000, 0, d, r);
      check_data("Unmapped region read data", d, 32'h0);
      check_resp("Unmapped region read", r, RESP_DECERR);
      axil_read(32'h1_0000, 0, d, r);
      check_data("Upper address read data", d, 32'h0);
      check_resp("Upper address read", r, RESP_DECERR);
      axil_write(32'h3000, $urandom, 4'hf, 0, r);
      check_resp("Unmapped region write", r, RESP_DECERR);
      axil_write(32'h1_0000, $urandom, 4'hf, 0, r);
      check_resp("Upper address write", r, RESP_DECERR);
      finish_test("Soft irq and decode", e0);
   endtask

   task automatic back_pressure();
      int    e0;
      data_t w;
      data_t d;
      resp_t r;
      e0 = err_count;
      axil_read(ROM_BASE + 32'hc, 5, d, r);
      check_data("Stalled ROM read", d, rom_exp[3]);
      check_resp("Stalled ROM read response", r, RESP_OKAY);
      w = $urandom;
      axil_write(GPIO_BASE, w, 4'hf, 5, r);
      check_resp("Stalled GPIO write", r, RESP_OKAY);
      check_data("o_gpio after stalled write", o_gpio, w);
      axil_read(GPIO_BASE, 0, d, r);
      check_data("Read after stalled write", d, w);
      check_resp("Read after stalled write response", r, RESP_OKAY);
      finish_test("Back-pressure", e0);
   endtask

   initial begin
      seed_val         = $urandom(32'h272c5b17);
      i_rst_n          = 1'b0;
      i_gpio           = '0;
      i_s_axil_awaddr  = '0;
      i_s_axil_awvalid = 1'b0;
      i_s_axil_wdata   = '0;
      i_s_axil_wstrb   = '0;
      i_s_axil_wvalid  = 1'b0;
      i_s_axil_bready  = 1'b0;
      i_s_axil_araddr  = '0;
      i_s_axil_arvalid = 1'b0;
      i_s_axil_rready  = 1'b0;
      $readmemh("bootrom.hex", rom_exp);
      repeat (10) @(posedge i_clk);
      #DRV_DLY;
      i_rst_n = 1'b1;
      rom_reads();
      rom_write();
      gpio_access();
      timer_irq();
      soft_irq_decerr();
      back_pressure();
      $display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
               pass_tests, fail_tests, err_count);
      if (err_count == 0 && fail_tests == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
